/* src/pipe_pkg.sv */
// pipeline package
// widths, operation codes, data ROM contents rule and hazard FSM
// state encoding shared by the integer back end and its testbench
package pipe_pkg;

	// datapath and register file
	localparam int XLEN   = 32;
	localparam int REG_AW = 5;
	localparam int IMM_W  = 12;

	// decoded operations
	localparam int OP_W = 2;
	localparam logic [OP_W-1:0] OP_ADD  = 2'd0;
	localparam logic [OP_W-1:0] OP_ADDI = 2'd1;
	localparam logic [OP_W-1:0] OP_LOAD = 2'd2;

	// data ROM, word k holds ROM_BASE + k * ROM_STRIDE
	localparam int ROM_AW    = 6;
	localparam int ROM_WORDS = 64;
	localparam logic [XLEN-1:0] ROM_BASE   = 32'h1357_0000;
	localparam logic [XLEN-1:0] ROM_STRIDE = 32'h0001_0203;

	// hazard unit states
	localparam logic HZ_RUN       = 1'b0;
	localparam logic HZ_WAIT_LOAD = 1'b1;

endpackage

/* src/reg_file.sv */
`timescale 1ns/1ps
// integer register file
// 32 x 32-bit, two combinational read ports and one synchronous write port,
// register zero always reads as zero
module reg_file (
	input  logic                        clock,
	input  logic                        reset,
	input  logic [pipe_pkg::REG_AW-1:0] rd_addr0_i,
	input  logic [pipe_pkg::REG_AW-1:0] rd_addr1_i,
	output logic [pipe_pkg::XLEN-1:0]   rd_data0_o,
	output logic [pipe_pkg::XLEN-1:0]   rd_data1_o,
	input  logic                        wr_en_i,
	input  logic [pipe_pkg::REG_AW-1:0] wr_addr_i,
	input  logic [pipe_pkg::XLEN-1:0]   wr_data_i
);

	logic [pipe_pkg::XLEN-1:0] regs [2**pipe_pkg::REG_AW];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < 2**pipe_pkg::REG_AW; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en_i && (wr_addr_i != '0)) begin
			// writes to r0 are dropped
			regs[wr_addr_i] <= wr_data_i;
		end
	end

	// no write-through, same-cycle writes come from the bypass
	assign rd_data0_o = (rd_addr0_i == '0) ? '0 : regs[rd_addr0_i];
	assign rd_data1_o = (rd_addr1_i == '0) ? '0 : regs[rd_addr1_i];

endmodule

/* src/hazard_unit.sv */
`timescale 1ns/1ps
// read-after-write hazard and bypass unit
// compares the issuing sources with the execute and memory destinations,
// forwards results that are ready and stalls issue behind loads in flight
module hazard_unit (
	input  logic                        clock,
	input  logic                        reset,
	input  logic [pipe_pkg::REG_AW-1:0] rs0_i,
	input  logic [pipe_pkg::REG_AW-1:0] rs1_i,
	input  logic                        ren0_i,
	input  logic                        ren1_i,
	input  logic                        issue_i,
	input  logic                        ex_busy_i,
	input  logic                        ex_is_load_i,
	input  logic [pipe_pkg::REG_AW-1:0] ex_rd_i,
	input  logic [pipe_pkg::XLEN-1:0]   ex_result_i,
	input  logic                        mem_busy_i,
	input  logic                        mem_is_load_i,
	input  logic [pipe_pkg::REG_AW-1:0] mem_rd_i,
	input  logic                        mem_done_i,
	input  logic [pipe_pkg::XLEN-1:0]   mem_data_i,
	output logic                        fwd0_o,
	output logic                        fwd1_o,
	output logic [pipe_pkg::XLEN-1:0]   bypass0_o,
	output logic [pipe_pkg::XLEN-1:0]   bypass1_o,
	output logic                        stall_o
);

	logic [pipe_pkg::REG_AW-1:0] src0;
	logic [pipe_pkg::REG_AW-1:0] src1;
	logic [pipe_pkg::REG_AW-1:0] ex_dst;
	logic [pipe_pkg::REG_AW-1:0] mem_dst;
	logic                        ex_m0;
	logic                        ex_m1;
	logic                        mem_m0;
	logic                        mem_m1;
	logic                        stall0;
	logic                        stall1;
	logic                        mem_load_pend;
	logic                        state_q;
	logic                        state_d;
	logic [pipe_pkg::XLEN-1:0]   load_q;

	// operand data for one source, execute first since it is younger
	function automatic logic [pipe_pkg::XLEN-1:0] pick(input logic ex_m, input logic mem_m);
		logic [pipe_pkg::XLEN-1:0] data;
		data = '0;
		if (ex_m) begin
			data = ex_result_i;
		end else if (mem_m && (!mem_is_load_i || mem_done_i)) begin
			// alu result, or the load word in its completion cycle
			data = mem_data_i;
		end else if (mem_m) begin
			data = load_q;
		end
		return data;
	endfunction

	// masked addresses, zero means nothing to compare
	assign src0    = (issue_i && ren0_i) ? rs0_i : '0;
	assign src1    = (issue_i && ren1_i) ? rs1_i : '0;
	assign ex_dst  = ex_busy_i ? ex_rd_i : '0;
	assign mem_dst = mem_busy_i ? mem_rd_i : '0;

	assign ex_m0  = (src0 != '0) && (src0 == ex_dst);
	assign ex_m1  = (src1 != '0) && (src1 == ex_dst);
	assign mem_m0 = (src0 != '0) && (src0 == mem_dst);
	assign mem_m1 = (src1 != '0) && (src1 == mem_dst);

	assign mem_load_pend = (mem_m0 || mem_m1) && mem_is_load_i && !mem_done_i;

	// an execute match shadows the older memory entry
	assign stall0 = ex_m0 ? ex_is_load_i : (mem_m0 && mem_is_load_i && !mem_done_i);
	assign stall1 = ex_m1 ? ex_is_load_i : (mem_m1 && mem_is_load_i && !mem_done_i);

	assign stall_o = stall0 || stall1 || ((state_q == pipe_pkg::HZ_WAIT_LOAD) && !mem_done_i);

	assign fwd0_o    = ex_m0 || mem_m0;
	assign fwd1_o    = ex_m1 || mem_m1;
	assign bypass0_o = pick(ex_m0, mem_m0);
	assign bypass1_o = pick(ex_m1, mem_m1);

	always_comb begin
		state_d = state_q;
		case (state_q)
			pipe_pkg::HZ_RUN: begin
				if (mem_load_pend) begin
					state_d = pipe_pkg::HZ_WAIT_LOAD;
				end
			end
			pipe_pkg::HZ_WAIT_LOAD: begin
				if (mem_done_i) begin
					state_d = pipe_pkg::HZ_RUN;
				end
			end
			default: state_d = pipe_pkg::HZ_RUN;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state_q <= pipe_pkg::HZ_RUN;
		end else begin
			state_q <= state_d;
		end
	end

	// keep the returned load word while issue is still held
	always_ff @(posedge clock) begin
		if (mem_done_i && (mem_m0 || mem_m1)) begin
			load_q <= mem_data_i;
		end
	end

endmodule

/* src/issue_stage.sv */
`timescale 1ns/1ps
// issue stage
// accepts decoded instructions, picks operands from the register file or
// the bypass network and launches them into execute when not stalled
module issue_stage (
	input  logic                        clock,
	input  logic                        reset,
	input  logic                        instr_valid_i,
	input  logic [pipe_pkg::OP_W-1:0]   instr_op_i,
	input  logic [pipe_pkg::REG_AW-1:0] instr_rs0_i,
	input  logic [pipe_pkg::REG_AW-1:0] instr_rs1_i,
	input  logic [pipe_pkg::REG_AW-1:0] instr_rd_i,
	input  logic [pipe_pkg::IMM_W-1:0]  instr_imm_i,
	output logic                        instr_ready_o,
	input  logic                        stall_i,
	input  logic                        hold_i,
	input  logic                        fwd0_i,
	input  logic                        fwd1_i,
	input  logic [pipe_pkg::XLEN-1:0]   bypass0_i,
	input  logic [pipe_pkg::XLEN-1:0]   bypass1_i,
	input  logic [pipe_pkg::XLEN-1:0]   rf_data0_i,
	input  logic [pipe_pkg::XLEN-1:0]   rf_data1_i,
	output logic                        ren0_o,
	output logic                        ren1_o,
	output logic [pipe_pkg::REG_AW-1:0] rs0_o,
	output logic [pipe_pkg::REG_AW-1:0] rs1_o,
	output logic                        issue_o,
	output logic [pipe_pkg::OP_W-1:0]   op_o,
	output logic [pipe_pkg::REG_AW-1:0] rd_o,
	output logic [pipe_pkg::XLEN-1:0]   opa_o,
	output logic [pipe_pkg::XLEN-1:0]   opb_o
);

	logic                      is_add;
	logic                      en_q;
	logic [pipe_pkg::XLEN-1:0] src0_data;
	logic [pipe_pkg::XLEN-1:0] src1_data;
	logic [pipe_pkg::XLEN-1:0] imm_ext;

	// issue opens once reset has been released
	always_ff @(posedge clock) begin
		if (reset) begin
			en_q <= 1'b0;
		end else begin
			en_q <= 1'b1;
		end
	end

	// read enables from the operation
	assign is_add = (instr_op_i == pipe_pkg::OP_ADD);
	assign ren0_o = is_add || (instr_op_i == pipe_pkg::OP_ADDI) ||
		(instr_op_i == pipe_pkg::OP_LOAD);
	assign ren1_o = is_add;

	assign rs0_o = ren0_o ? instr_rs0_i : '0;
	assign rs1_o = ren1_o ? instr_rs1_i : '0;

	assign src0_data = fwd0_i ? bypass0_i : rf_data0_i;
	assign src1_data = fwd1_i ? bypass1_i : rf_data1_i;
	assign imm_ext   = {{(pipe_pkg::XLEN-pipe_pkg::IMM_W){instr_imm_i[pipe_pkg::IMM_W-1]}},
		instr_imm_i};

	// launch on the handshake
	assign instr_ready_o = en_q && !stall_i && !hold_i;
	assign issue_o       = instr_valid_i && instr_ready_o;

	assign op_o  = instr_op_i;
	assign rd_o  = instr_rd_i;
	assign opa_o = src0_data;
	// second operand is rs1 only for ADD
	assign opb_o = is_add ? src1_data : imm_ext;

endmodule

/* src/exec_stage.sv */
`timescale 1ns/1ps
// execute stage
// pipeline register holding the operation tag, destination and sum,
// frozen while the memory stage waits on a load
module exec_stage (
	input  logic                        clock,
	input  logic                        reset,
	input  logic                        issue_i,
	input  logic [pipe_pkg::OP_W-1:0]   op_i,
	input  logic [pipe_pkg::REG_AW-1:0] rd_i,
	input  logic [pipe_pkg::XLEN-1:0]   opa_i,
	input  logic [pipe_pkg::XLEN-1:0]   opb_i,
	input  logic                        hold_i,
	output logic                        busy_o,
	output logic                        is_load_o,
	output logic [pipe_pkg::REG_AW-1:0] rd_o,
	output logic [pipe_pkg::XLEN-1:0]   result_o,
	output logic                        hold_o
);

	logic                        busy_q;
	logic [pipe_pkg::OP_W-1:0]   op_q;
	logic [pipe_pkg::REG_AW-1:0] rd_q;
	logic [pipe_pkg::XLEN-1:0]   sum;
	logic [pipe_pkg::XLEN-1:0]   sum_q;

	// one adder serves all three operations
	assign sum = opa_i + opb_i;

	always_ff @(posedge clock) begin
		if (reset) begin
			busy_q <= 1'b0;
		end else if (!hold_i) begin
			// empties when nothing new arrives
			busy_q <= issue_i;
		end
	end

	always_ff @(posedge clock) begin
		if (issue_i && !hold_i) begin
			op_q  <= op_i;
			rd_q  <= rd_i;
			sum_q <= sum;
		end
	end

	assign busy_o    = busy_q;
	assign is_load_o = busy_q && (op_q == pipe_pkg::OP_LOAD);
	assign rd_o      = rd_q;
	assign result_o  = sum_q;

	// a held memory stage blocks this register, so issue stops too
	assign hold_o = hold_i;

endmodule

/* src/mem_stage.sv */
`timescale 1ns/1ps
// memory stage
// passes ALU sums through in one cycle or reads the data ROM with a
// variable wait, then drives writeback to the register file
module mem_stage (
	input  logic                        clock,
	input  logic                        reset,
	input  logic                        ex_busy_i,
	input  logic                        ex_is_load_i,
	input  logic [pipe_pkg::REG_AW-1:0] ex_rd_i,
	input  logic [pipe_pkg::XLEN-1:0]   ex_result_i,
	input  logic                        mem_wait_i,
	output logic                        hold_o,
	output logic                        busy_o,
	output logic                        is_load_o,
	output logic [pipe_pkg::REG_AW-1:0] rd_o,
	output logic                        done_o,
	output logic [pipe_pkg::XLEN-1:0]   data_o,
	output logic                        wb_valid_o,
	output logic [pipe_pkg::REG_AW-1:0] wb_rd_o,
	output logic [pipe_pkg::XLEN-1:0]   wb_data_o
);

	logic                        busy_q;
	logic                        load_q;
	logic [pipe_pkg::REG_AW-1:0] rd_q;
	logic [pipe_pkg::XLEN-1:0]   result_q;
	logic [pipe_pkg::ROM_AW-1:0] rom_idx;
	logic [pipe_pkg::XLEN-1:0]   rom_word;
	logic [pipe_pkg::XLEN-1:0]   rom [pipe_pkg::ROM_WORDS];

	// constant data ROM
	for (genvar k = 0; k < pipe_pkg::ROM_WORDS; k++) begin : g_rom
		assign rom[k] = pipe_pkg::ROM_BASE + pipe_pkg::ROM_STRIDE * k;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			busy_q <= 1'b0;
		end else if (!hold_o) begin
			busy_q <= ex_busy_i;
		end
	end

	always_ff @(posedge clock) begin
		if (!hold_o && ex_busy_i) begin
			load_q   <= ex_is_load_i;
			rd_q     <= ex_rd_i;
			result_q <= ex_result_i;
		end
	end

	// address wraps to the ROM size
	assign rom_idx  = result_q[pipe_pkg::ROM_AW-1:0];
	assign rom_word = rom[rom_idx];

	// load finishes on the first cycle without wait
	assign done_o = busy_q && load_q && !mem_wait_i;
	assign hold_o = busy_q && load_q && mem_wait_i;

	assign busy_o    = busy_q;
	assign is_load_o = busy_q && load_q;
	assign rd_o      = rd_q;
	assign data_o    = load_q ? rom_word : result_q;

	// one pulse per instruction, in program order
	assign wb_valid_o = busy_q && (!load_q || !mem_wait_i);
	assign wb_rd_o    = rd_q;
	assign wb_data_o  = data_o;

endmodule

/* src/pipe_top.sv */
`timescale 1ns/1ps
// in-order integer back end
// issue, execute and memory stages with the hazard unit and register file
module pipe_top (
	input  logic                        clock,
	input  logic                        reset,
	input  logic                        instr_valid_i,
	input  logic [pipe_pkg::OP_W-1:0]   instr_op_i,
	input  logic [pipe_pkg::REG_AW-1:0] instr_rs0_i,
	input  logic [pipe_pkg::REG_AW-1:0] instr_rs1_i,
	input  logic [pipe_pkg::REG_AW-1:0] instr_rd_i,
	input  logic [pipe_pkg::IMM_W-1:0]  instr_imm_i,
	input  logic                        mem_wait_i,
	output logic                        instr_ready_o,
	output logic                        wb_valid_o,
	output logic [pipe_pkg::REG_AW-1:0] wb_rd_o,
	output logic [pipe_pkg::XLEN-1:0]   wb_data_o
);

	logic                        ren0, ren1, issue, stall, fwd0, fwd1;
	logic                        ex_hold, mem_hold;
	logic [pipe_pkg::REG_AW-1:0] rs0, rs1, iss_rd;
	logic [pipe_pkg::OP_W-1:0]   iss_op;
	logic [pipe_pkg::XLEN-1:0]   rf_data0, rf_data1, bypass0, bypass1, opa, opb;
	logic                        ex_busy, ex_is_load;
	logic [pipe_pkg::REG_AW-1:0] ex_rd;
	logic [pipe_pkg::XLEN-1:0]   ex_result;
	logic                        mem_busy, mem_is_load, mem_done;
	logic [pipe_pkg::REG_AW-1:0] mem_rd;
	logic [pipe_pkg::XLEN-1:0]   mem_data;

	issue_stage u_issue (
		.clock, .reset, .instr_valid_i, .instr_op_i, .instr_rs0_i, .instr_rs1_i,
		.instr_rd_i, .instr_imm_i, .instr_ready_o, .stall_i(stall), .hold_i(ex_hold),
		.fwd0_i(fwd0), .fwd1_i(fwd1), .bypass0_i(bypass0), .bypass1_i(bypass1),
		.rf_data0_i(rf_data0), .rf_data1_i(rf_data1), .ren0_o(ren0), .ren1_o(ren1),
		.rs0_o(rs0), .rs1_o(rs1), .issue_o(issue), .op_o(iss_op), .rd_o(iss_rd),
		.opa_o(opa), .opb_o(opb)
	);

	exec_stage u_exec (
		.clock, .reset, .issue_i(issue), .op_i(iss_op), .rd_i(iss_rd), .opa_i(opa),
		.opb_i(opb), .hold_i(mem_hold), .busy_o(ex_busy), .is_load_o(ex_is_load),
		.rd_o(ex_rd), .result_o(ex_result), .hold_o(ex_hold)
	);

	mem_stage u_mem (
		.clock, .reset, .ex_busy_i(ex_busy), .ex_is_load_i(ex_is_load), .ex_rd_i(ex_rd),
		.ex_result_i(ex_result), .mem_wait_i, .hold_o(mem_hold), .busy_o(mem_busy),
		.is_load_o(mem_is_load), .rd_o(mem_rd), .done_o(mem_done), .data_o(mem_data),
		.wb_valid_o, .wb_rd_o, .wb_data_o
	);

	// compares against the instruction waiting at issue
	hazard_unit u_hazard (
		.clock, .reset, .rs0_i(rs0), .rs1_i(rs1), .ren0_i(ren0), .ren1_i(ren1),
		.issue_i(instr_valid_i), .ex_busy_i(ex_busy), .ex_is_load_i(ex_is_load),
		.ex_rd_i(ex_rd), .ex_result_i(ex_result), .mem_busy_i(mem_busy),
		.mem_is_load_i(mem_is_load), .mem_rd_i(mem_rd), .mem_done_i(mem_done),
		.mem_data_i(mem_data), .fwd0_o(fwd0), .fwd1_o(fwd1), .bypass0_o(bypass0),
		.bypass1_o(bypass1), .stall_o(stall)
	);

	reg_file u_rf (
		.clock, .reset, .rd_addr0_i(rs0), .rd_addr1_i(rs1), .rd_data0_o(rf_data0),
		.rd_data1_o(rf_data1), .wr_en_i(wb_valid_o), .wr_addr_i(wb_rd_o),
		.wr_data_i(wb_data_o)
	);

endmodule

/* testbench/pipe_assertions.sv */
`timescale 1ns/1ps
// pipeline checker, bound into the back end top
// compares every writeback with the head of the reference queue and checks
// the load-use stall, ALU latency, load wait and post-reset levels
module pipe_assertions (
	input logic                        clock, reset,
	input logic                        instr_valid_i, instr_ready_i, mem_wait_i,
	input logic [pipe_pkg::OP_W-1:0]   instr_op_i,
	input logic                        wb_valid_i, exp_valid_i,
	input logic [pipe_pkg::REG_AW-1:0] wb_rd_i, exp_rd_i,
	input logic [pipe_pkg::XLEN-1:0]   wb_data_i, exp_data_i,
	input logic                        ren0_i, ren1_i,
	input logic [pipe_pkg::REG_AW-1:0] rs0_i, rs1_i, ex_rd_i, mem_rd_i,
	input logic                        ex_busy_i, ex_is_load_i, mem_busy_i,
	input logic                        mem_is_load_i, mem_done_i, mem_hold_i
);

	int   mismatch_count = 0;
	int   error_count = 0;
	logic ex_hit0, ex_hit1, mem_hit0, mem_hit1, load_dep;

	assign ex_hit0  = ren0_i && (rs0_i != '0) && ex_busy_i && (rs0_i == ex_rd_i);
	assign ex_hit1  = ren1_i && (rs1_i != '0) && ex_busy_i && (rs1_i == ex_rd_i);
	assign mem_hit0 = ren0_i && (rs0_i != '0) && mem_busy_i && (rs0_i == mem_rd_i);
	assign mem_hit1 = ren1_i && (rs1_i != '0) && mem_busy_i && (rs1_i == mem_rd_i);

	// a source needs a load word that is not there yet, execute shadows memory
	assign load_dep = instr_valid_i && ((ex_is_load_i && (ex_hit0 || ex_hit1)) ||
		(mem_is_load_i && !mem_done_i && ((mem_hit0 && !ex_hit0) || (mem_hit1 && !ex_hit1))));

	wb_rd_check: assert property (@(posedge clock) disable iff (reset)
		wb_valid_i |-> exp_valid_i && (wb_rd_i == exp_rd_i)) else begin
		mismatch_count++;
		$error("ERROR wb_rd_o got %h expected %h", $sampled(wb_rd_i), $sampled(exp_rd_i));
	end
	wb_data_check: assert property (@(posedge clock) disable iff (reset)
		wb_valid_i && exp_valid_i |-> wb_data_i == exp_data_i) else begin
		mismatch_count++;
		$error("ERROR wb_data_o got %h expected %h", $sampled(wb_data_i), $sampled(exp_data_i));
	end
	load_use_check: assert property (@(posedge clock) disable iff (reset)
		load_dep |-> !instr_ready_i) else begin
		error_count++;
		$error("dependent instruction was accepted before its load returned");
	end
	alu_latency_check: assert property (@(posedge clock) disable iff (reset)
		instr_valid_i && instr_ready_i && (instr_op_i != pipe_pkg::OP_LOAD) ##1 !mem_hold_i
		|=> wb_valid_i) else begin
		error_count++;
		$error("ALU instruction did not write back two cycles after acceptance");
	end
	load_wait_check: assert property (@(posedge clock) disable iff (reset)
		mem_is_load_i && mem_wait_i |-> !wb_valid_i && !instr_ready_i) else begin
		error_count++;
		$error("writeback or issue went ahead while a load was waiting");
	end
	reset_check: assert property (@(posedge clock)
		$fell(reset) |-> !wb_valid_i ##1 instr_ready_i) else begin
		error_count++;
		$error("wrong writeback or ready level after reset");
	end

endmodule

/* testbench/pipe_tb.sv */
`timescale 1ns/1ps
// testbench for the integer back end
// random decoded instructions over r0..r3 with frequent hazards, a reference
// register model feeding the expected writeback queue of the bound checker
module pipe_tb;

	localparam int num_instr = 400;

	logic                        clock, reset, instr_valid_i, mem_wait_i;
	logic [pipe_pkg::OP_W-1:0]   instr_op_i;
	logic [pipe_pkg::REG_AW-1:0] instr_rs0_i, instr_rs1_i, instr_rd_i, wb_rd_o, exp_rd;
	logic [pipe_pkg::IMM_W-1:0]  instr_imm_i;
	logic                        instr_ready_o, wb_valid_o, exp_valid;
	logic [pipe_pkg::XLEN-1:0]   wb_data_o, exp_data;
	logic [pipe_pkg::XLEN-1:0]   model [2**pipe_pkg::REG_AW];
	logic [pipe_pkg::REG_AW+pipe_pkg::XLEN-1:0] exp_q [$];
	logic [31:0]                 lfsr;
	int                          sent, wb_count, wait_left;

	pipe_top DUT (.*);

	bind pipe_top pipe_assertions u_chk (
		.clock, .reset, .instr_valid_i, .instr_ready_i(instr_ready_o), .mem_wait_i,
		.instr_op_i, .wb_valid_i(wb_valid_o), .wb_rd_i(wb_rd_o), .wb_data_i(wb_data_o),
		.exp_valid_i(pipe_tb.exp_valid), .exp_rd_i(pipe_tb.exp_rd),
		.exp_data_i(pipe_tb.exp_data), .ren0_i(ren0), .ren1_i(ren1), .rs0_i(rs0),
		.rs1_i(rs1), .ex_rd_i(ex_rd), .mem_rd_i(mem_rd), .ex_busy_i(ex_busy),
		.ex_is_load_i(ex_is_load), .mem_busy_i(mem_busy), .mem_is_load_i(mem_is_load),
		.mem_done_i(mem_done), .mem_hold_i(mem_hold)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	// galois lfsr, one step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic logic [pipe_pkg::REG_AW-1:0] pick_reg();
		logic [31:0] r;
		r = rand_bits(2);
		return r[pipe_pkg::REG_AW-1:0];
	endfunction

	// expected result from the operation rules and the ROM contents rule
	function automatic logic [pipe_pkg::XLEN-1:0] predict(
		input logic [pipe_pkg::OP_W-1:0] op, input logic [pipe_pkg::REG_AW-1:0] rs0,
		input logic [pipe_pkg::REG_AW-1:0] rs1, input logic [pipe_pkg::IMM_W-1:0] imm);
		logic [pipe_pkg::XLEN-1:0] b;
		logic [pipe_pkg::XLEN-1:0] sum;
		logic [pipe_pkg::XLEN-1:0] idx;
		b = (op == pipe_pkg::OP_ADD) ? model[rs1] :
			{{(pipe_pkg::XLEN-pipe_pkg::IMM_W){imm[pipe_pkg::IMM_W-1]}}, imm};
		sum = model[rs0] + b;
		if (op != pipe_pkg::OP_LOAD) begin
			return sum;
		end
		idx = sum % pipe_pkg::ROM_WORDS;
		return pipe_pkg::ROM_BASE + pipe_pkg::ROM_STRIDE * idx;
	endfunction

	// next instruction, rs0 often reuses the last destination
	task automatic new_instr();
		logic [31:0] r;
		r = rand_bits(2);
		instr_op_i <= (r == 0) ? pipe_pkg::OP_ADD :
			(r == 1) ? pipe_pkg::OP_ADDI : pipe_pkg::OP_LOAD;
		instr_rs0_i <= (rand_bits(1) != 0) ? instr_rd_i : pick_reg();
		instr_rs1_i <= pick_reg();
		instr_rd_i  <= pick_reg();
		r = rand_bits(pipe_pkg::IMM_W);
		instr_imm_i   <= r[pipe_pkg::IMM_W-1:0];
		instr_valid_i <= 1'b1;
	endtask

	// reference registers and expected writebacks in program order
	always @(posedge clock) begin : track
		logic [pipe_pkg::XLEN-1:0] data;
		if (reset) begin
			model = '{default: '0};
			exp_q.delete();
			wb_count = 0;
		end else begin
			if (wb_valid_o) begin
				wb_count++;
				if (exp_q.size() > 0) begin
					void'(exp_q.pop_front());
				end
			end
			if (instr_valid_i && instr_ready_o) begin
				data = predict(instr_op_i, instr_rs0_i, instr_rs1_i, instr_imm_i);
				if (instr_rd_i != '0) begin
					model[instr_rd_i] = data;
				end
				exp_q.push_back({instr_rd_i, data});
			end
		end
		exp_valid = (exp_q.size() > 0);
		{exp_rd, exp_data} = exp_valid ? exp_q[0] : '0;
	end

	initial begin
		instr_valid_i = 1'b0;
		instr_op_i    = pipe_pkg::OP_ADD;
		instr_rs0_i   = '0;
		instr_rs1_i   = '0;
		instr_rd_i    = '0;
		instr_imm_i   = '0;
		mem_wait_i    = 1'b0;
		reset         = 1'b1;
		lfsr          = 32'hf6e9;
		sent          = 0;
		wait_left     = 0;
		repeat (5) @(posedge clock);
		reset <= 1'b0;
		repeat (2) @(posedge clock);
		while (sent < num_instr) begin
			if (instr_valid_i && instr_ready_o) begin
				sent++;
			end
			// mostly back to back, an idle cycle now and then
			if (!instr_valid_i || instr_ready_o) begin
				if ((sent < num_instr) && (rand_bits(3) != 0)) begin
					new_instr();
				end else begin
					instr_valid_i <= 1'b0;
				end
			end
			// memory wait stretches of zero to four cycles
			if (wait_left > 0) begin
				mem_wait_i <= 1'b1;
				wait_left--;
			end else begin
				mem_wait_i <= 1'b0;
				if (rand_bits(2) == 0) begin
					wait_left = rand_bits(3) % 5;
				end
			end
			@(posedge clock);
		end
		mem_wait_i <= 1'b0;
		while (exp_q.size() > 0) begin
			@(posedge clock);
		end
		repeat (3) @(posedge clock);
		if (wb_count != num_instr) begin
			$display("writeback count does not match the %0d accepted instructions", num_instr);
		end
		$display("writebacks %0d, mismatches %0d, assertion errors %0d", wb_count,
			DUT.u_chk.mismatch_count, DUT.u_chk.error_count);
		if ((wb_count == num_instr) && (DUT.u_chk.mismatch_count == 0) &&
			(DUT.u_chk.error_count == 0)) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

	// watchdog, eight cycles per instruction
	initial begin
		repeat (num_instr * 8) @(posedge clock);
		$display("timeout, writebacks did not drain within %0d cycles", num_instr * 8);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

/* list.f */
src/pipe_pkg.sv
src/reg_file.sv
src/hazard_unit.sv
src/issue_stage.sv
src/exec_stage.sv
src/mem_stage.sv
src/pipe_top.sv
testbench/pipe_assertions.sv
testbench/pipe_tb.sv
